/* src/cpu_pkg.sv */
package cpu_pkg;

    // data word and instruction field widths
    localparam int data_w = 16;
    localparam int op_w = 4;
    // operand address field, fixed by the instruction format
    localparam int field_w = data_w - op_w;

    // instruction set, one opcode per value
    typedef enum logic [op_w-1:0] {
        op_load   = 4'd0,
        op_store  = 4'd1,
        op_add    = 4'd2,
        op_sub    = 4'd3,
        op_and    = 4'd4,
        op_or     = 4'd5,
        op_xor    = 4'd6,
        op_shl    = 4'd7,
        op_shr    = 4'd8,
        op_rol    = 4'd9,
        op_ror    = 4'd10,
        op_cmp_gt = 4'd11,
        op_cmp_eq = 4'd12,
        op_jmp    = 4'd13,
        op_jz     = 4'd14,
        op_halt   = 4'd15
    } opcode_e;

    // opcode on top, operand address below
    typedef struct packed {
        opcode_e              opcode;
        logic [field_w-1:0]   addr;
    } instr_t;

    // one memory word, seen as an instruction in decode
    // and as an operand value in execute
    typedef union packed {
        instr_t              instr;
        logic [data_w-1:0]   data;
    } mem_word_u;

    // source of the cpu side memory address
    typedef enum logic [1:0] {
        from_pc    = 2'd0,
        from_fetch = 2'd1,
        from_ir    = 2'd2
    } addr_sel_e;

    // control word from the fsm to datapath and memory
    typedef struct packed {
        logic        ir_load;
        logic        acc_load;
        logic        mem_we;
        addr_sel_e   addr_sel;
    } ctrl_t;

    // load and every alu opcode write the accumulator
    function automatic logic writes_acc(opcode_e op);
        return (op == op_load) || ((op >= op_add) && (op <= op_cmp_eq));
    endfunction

endpackage

/* src/main_memory.sv */
`timescale 1ns/1ps

module main_memory #(
    parameter int ADDR_W = 8
) (
    input  logic                          clk,
    // cpu port
    input  logic [ADDR_W-1:0]             cpu_addr,
    input  logic                          cpu_we,
    input  logic [cpu_pkg::data_w-1:0]    cpu_wdata,
    output cpu_pkg::mem_word_u            cpu_rdata,
    // host port used only while the cpu is stopped
    input  logic [ADDR_W-1:0]             host_addr,
    input  logic                          host_we,
    input  logic [cpu_pkg::data_w-1:0]    host_wdata,
    output logic [cpu_pkg::data_w-1:0]    host_rdata
);

    localparam int depth = 2 ** ADDR_W;

    // word storage holds nothing defined until loaded
    logic [cpu_pkg::data_w-1:0] mem [depth];

    // both ports write the same word array
    // cpu and host never write in the same cycle since host waits for !busy
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_wdata;
        end
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        // read every cycle and hold the output on a write
        // no read-through of the new word
        if (!cpu_we) begin
            cpu_rdata.data <= mem[cpu_addr];
        end
        if (!host_we) begin
            host_rdata <= mem[host_addr];
        end
    end

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::opcode_e               op,
    input  logic [cpu_pkg::data_w-1:0]     acc_in,
    input  logic [cpu_pkg::data_w-1:0]     operand,
    output logic [cpu_pkg::data_w-1:0]     result
);

    localparam int msb = cpu_pkg::data_w - 1;

    // single-bit shift and rotate amounts, acc only
    always_comb begin
        case (op)
            // operand straight into the accumulator
            cpu_pkg::op_load: result = operand;
            // arithmetic wraps mod 2^16
            cpu_pkg::op_add: result = acc_in + operand;
            cpu_pkg::op_sub: result = acc_in - operand;
            // bitwise logic
            cpu_pkg::op_and: result = acc_in & operand;
            cpu_pkg::op_or: result = acc_in | operand;
            cpu_pkg::op_xor: result = acc_in ^ operand;
            // zero fill on shifts
            cpu_pkg::op_shl: result = acc_in << 1;
            cpu_pkg::op_shr: result = acc_in >> 1;
            // end bit wraps around
            cpu_pkg::op_rol: result = {acc_in[msb-1:0], acc_in[msb]};
            cpu_pkg::op_ror: result = {acc_in[0], acc_in[msb:1]};
            // unsigned compares, result 1 or 0
            cpu_pkg::op_cmp_gt: begin
                result = (acc_in > operand) ? cpu_pkg::data_w'(1) : '0;
            end
            cpu_pkg::op_cmp_eq: begin
                result = (acc_in == operand) ? cpu_pkg::data_w'(1) : '0;
            end
            // store, jumps and halt keep acc
            default: result = acc_in;
        endcase
    end

endmodule

/* src/program_counter.sv */
`timescale 1ns/1ps

module program_counter #(
    parameter int ADDR_W = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear,
    input  logic                 inc,
    input  logic                 jump,
    input  logic [ADDR_W-1:0]    target,
    output logic [ADDR_W-1:0]    pc
);

    // next sequential address
    // ADDR_W bits wide, so the top word wraps to 0
    logic [ADDR_W-1:0] pc_next_seq;

    assign pc_next_seq = pc + 1'b1;

    // clear beats jump, jump beats increment
    // no request holds the pc, e.g. on halt
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (clear) begin
            pc <= '0;
        end else if (jump) begin
            pc <= target;
        end else if (inc) begin
            pc <= pc_next_seq;
        end
    end

endmodule

/* src/datapath.sv */
`timescale 1ns/1ps

module datapath #(
    parameter int ADDR_W = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  cpu_pkg::ctrl_t                ctrl,
    input  logic [ADDR_W-1:0]             pc,
    input  cpu_pkg::mem_word_u            mem_rdata,
    output logic [ADDR_W-1:0]             mem_addr,
    output logic [cpu_pkg::data_w-1:0]    mem_wdata,
    output cpu_pkg::opcode_e              opcode,
    output logic [ADDR_W-1:0]             target,
    output logic [cpu_pkg::data_w-1:0]    acc,
    output logic                          acc_zero
);

    // instruction register
    cpu_pkg::instr_t ir;
    // alu output toward the accumulator
    logic [cpu_pkg::data_w-1:0] alu_result;

    // ir captures the memory word at the end of decode
    // opcode reads as load out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (ctrl.ir_load) begin
            ir <= mem_rdata.instr;
        end
    end

    // accumulator written in execute for load and alu ops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (ctrl.acc_load) begin
            acc <= alu_result;
        end
    end

    // memory address select
    // decode already points at the operand of the word being fetched
    // so the operand is on the bus in execute
    always_comb begin
        case (ctrl.addr_sel)
            cpu_pkg::from_fetch: mem_addr = mem_rdata.instr.addr[ADDR_W-1:0];
            cpu_pkg::from_ir: mem_addr = ir.addr[ADDR_W-1:0];
            default: mem_addr = pc;
        endcase
    end

    // store writes the accumulator
    assign mem_wdata = acc;

    // decoded fields back to fsm and pc
    assign opcode = ir.opcode;
    assign target = ir.addr[ADDR_W-1:0];

    // zero flag for jz
    assign acc_zero = (acc == '0);

    // operand is the same memory word, read as data in execute
    alu u_alu (
        .op      (ir.opcode),
        .acc_in  (acc),
        .operand (mem_rdata.data),
        .result  (alu_result)
    );

endmodule

/* src/control_fsm.sv */
`timescale 1ns/1ps

module control_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  cpu_pkg::opcode_e      opcode,
    input  logic                  acc_zero,
    output cpu_pkg::ctrl_t        ctrl,
    output logic                  pc_clear,
    output logic                  pc_inc,
    output logic                  pc_jump,
    output logic                  busy,
    output logic                  halted
);

    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_fetch   = 3'd1,
        st_decode  = 3'd2,
        st_execute = 3'd3,
        st_halt    = 3'd4
    } state_e;

    state_e state;
    state_e state_next;

    // start only counts while stopped
    logic start_ok;
    // jump taken in execute
    logic take_jump;

    assign start_ok = start && ((state == st_idle) || (state == st_halt));

    assign take_jump = (opcode == cpu_pkg::op_jmp) ||
                       ((opcode == cpu_pkg::op_jz) && acc_zero);

    // state register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // next state, three cycles per instruction
    always_comb begin
        state_next = state;
        case (state)
            st_idle, st_halt: begin
                if (start_ok) begin
                    state_next = st_fetch;
                end
            end
            st_fetch: state_next = st_decode;
            st_decode: state_next = st_execute;
            st_execute: begin
                if (opcode == cpu_pkg::op_halt) begin
                    state_next = st_halt;
                end else begin
                    state_next = st_fetch;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    // datapath, memory and pc controls
    always_comb begin
        ctrl = '0;
        pc_inc = 1'b0;
        pc_jump = 1'b0;
        case (state)
            // pc drives the address, instruction comes back in decode
            st_fetch: ctrl.addr_sel = cpu_pkg::from_pc;
            st_decode: begin
                ctrl.ir_load = 1'b1;
                // start the operand read early
                ctrl.addr_sel = cpu_pkg::from_fetch;
            end
            st_execute: begin
                // store target address stays on the bus
                ctrl.addr_sel = cpu_pkg::from_ir;
                ctrl.mem_we = (opcode == cpu_pkg::op_store);
                ctrl.acc_load = cpu_pkg::writes_acc(opcode);
                // halt holds pc where it is
                if (take_jump) begin
                    pc_jump = 1'b1;
                end else if (opcode != cpu_pkg::op_halt) begin
                    pc_inc = 1'b1;
                end
            end
            default: ctrl.addr_sel = cpu_pkg::from_pc;
        endcase
    end

    // new run always begins at address 0
    assign pc_clear = start_ok;

    // status levels
    assign busy = (state == st_fetch) || (state == st_decode) || (state == st_execute);
    assign halted = (state == st_halt);

endmodule

/* src/accumulator_cpu.sv */
`timescale 1ns/1ps

module accumulator_cpu #(
    parameter int ADDR_W = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    // host access to memory while stopped
    input  logic                          host_we,
    input  logic [ADDR_W-1:0]             host_addr,
    input  logic [cpu_pkg::data_w-1:0]    host_wdata,
    output logic [cpu_pkg::data_w-1:0]    host_rdata,
    // run status
    output logic                          busy,
    output logic                          halted,
    // visible machine state
    output logic [cpu_pkg::data_w-1:0]    acc,
    output logic [ADDR_W-1:0]             pc
);

    // fsm controls
    cpu_pkg::ctrl_t ctrl;
    logic pc_clear;
    logic pc_inc;
    logic pc_jump;

    // datapath back to fsm and pc
    cpu_pkg::opcode_e opcode;
    logic acc_zero;
    logic [ADDR_W-1:0] target;

    // cpu memory port
    logic [ADDR_W-1:0] mem_addr;
    logic [cpu_pkg::data_w-1:0] mem_wdata;
    cpu_pkg::mem_word_u mem_rdata;

    control_fsm u_control_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .opcode   (opcode),
        .acc_zero (acc_zero),
        .ctrl     (ctrl),
        .pc_clear (pc_clear),
        .pc_inc   (pc_inc),
        .pc_jump  (pc_jump),
        .busy     (busy),
        .halted   (halted)
    );

    program_counter #(.ADDR_W(ADDR_W)) u_program_counter (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (pc_clear),
        .inc    (pc_inc),
        .jump   (pc_jump),
        .target (target),
        .pc     (pc)
    );

    datapath #(.ADDR_W(ADDR_W)) u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .pc        (pc),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .opcode    (opcode),
        .target    (target),
        .acc       (acc),
        .acc_zero  (acc_zero)
    );

    main_memory #(.ADDR_W(ADDR_W)) u_main_memory (
        .clk        (clk),
        .cpu_addr   (mem_addr),
        .cpu_we     (ctrl.mem_we),
        .cpu_wdata  (mem_wdata),
        .cpu_rdata  (mem_rdata),
        .host_addr  (host_addr),
        .host_we    (host_we),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

endmodule

/* sim/cpu_asserts.sv */
`timescale 1ns/1ps

module cpu_asserts (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic host_we,
    input logic busy,
    input logic halted
);

    // failed assertions so far, watched from the testbench
    int fail_count = 0;

    // running and stopped never overlap
    busy_halted_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && halted))
        else begin
            $error("busy and halted high in the same cycle");
            fail_count++;
        end

    // start seen while stopped begins a run one cycle later
    start_to_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |=> busy)
        else begin
            $error("accepted start did not raise busy");
            fail_count++;
        end

    // halted only drops on a new start
    halted_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (halted && !start) |=> halted)
        else begin
            $error("halted dropped without a start");
            fail_count++;
        end

    // host port stays off memory during a run
    no_host_write_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(host_we && busy))
        else begin
            $error("host write while busy");
            fail_count++;
        end

endmodule

bind accumulator_cpu cpu_asserts u_cpu_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .host_we (host_we),
    .busy    (busy),
    .halted  (halted)
);

/* sim/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam int addr_w = 8;
    localparam int data_w = cpu_pkg::data_w;
    localparam int depth = 2 ** addr_w;
    // code at the bottom and operands in the upper half
    localparam int data_base = depth / 2;
    localparam int n_random = 6;
    localparam int rand_len = 24;
    // most instructions any one run executes including the loop
    localparam int max_exec = 64;
    localparam int n_runs = n_random + 2;
    // host load and readback take one pass each over memory
    localparam int host_cycles = 2 * depth + 8;
    localparam int timeout_cycles = 2 * n_runs * (4 * max_exec + host_cycles) + 20;

    logic clk;
    logic rst_n;
    logic start;
    logic host_we;
    logic [addr_w-1:0] host_addr;
    logic [data_w-1:0] host_wdata;
    logic [data_w-1:0] host_rdata;
    logic busy;
    logic halted;
    logic [data_w-1:0] acc;
    logic [addr_w-1:0] pc;

    // image to load, and reference machine state
    logic [data_w-1:0] image [depth];
    logic [data_w-1:0] ref_mem [depth];
    logic [data_w-1:0] ref_acc;
    logic [addr_w-1:0] ref_pc;
    int ref_steps;
    logic [31:0] rng;
    int cycle_count = 0;

    accumulator_cpu #(.ADDR_W(addr_w)) uut (
        .clk(clk), .rst_n(rst_n), .start(start),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata), .busy(busy), .halted(halted), .acc(acc), .pc(pc)
    );

    always #10 clk = ~clk;

    // run length guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout, no end of test after %0d cycles", cycle_count);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    // bound control timing checker
    always @(negedge clk) begin
        if (uut.u_cpu_asserts.fail_count != 0) begin
            $display("a control timing assertion failed");
            $display("Some tests failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // reference run from address 0 until halt
    // acc carries over between runs and only reset clears it
    task automatic interpret();
        logic [data_w-1:0] word;
        logic [data_w-1:0] opnd;
        logic [addr_w-1:0] a;
        logic [addr_w-1:0] next_pc;
        bit done;
        ref_pc = '0;
        ref_steps = 0;
        done = 0;
        while (!done && ref_steps < max_exec) begin
            word = ref_mem[ref_pc];
            // only the low address bits reach memory
            a = word[addr_w-1:0];
            opnd = ref_mem[a];
            next_pc = addr_w'(ref_pc + 1);
            ref_steps++;
            case (word[15:12])
                cpu_pkg::op_load: ref_acc = opnd;
                cpu_pkg::op_store: ref_mem[a] = ref_acc;
                cpu_pkg::op_add: ref_acc = ref_acc + opnd;
                cpu_pkg::op_sub: ref_acc = ref_acc - opnd;
                cpu_pkg::op_and: ref_acc = ref_acc & opnd;
                cpu_pkg::op_or: ref_acc = ref_acc | opnd;
                cpu_pkg::op_xor: ref_acc = ref_acc ^ opnd;
                cpu_pkg::op_shl: ref_acc = ref_acc << 1;
                cpu_pkg::op_shr: ref_acc = ref_acc >> 1;
                cpu_pkg::op_rol: ref_acc = {ref_acc[14:0], ref_acc[15]};
                cpu_pkg::op_ror: ref_acc = {ref_acc[0], ref_acc[15:1]};
                cpu_pkg::op_cmp_gt: ref_acc = (ref_acc > opnd) ? 16'd1 : 16'd0;
                cpu_pkg::op_cmp_eq: ref_acc = (ref_acc == opnd) ? 16'd1 : 16'd0;
                cpu_pkg::op_jmp: next_pc = a;
                cpu_pkg::op_jz: next_pc = (ref_acc == 0) ? a : next_pc;
                default: begin
                    // halt keeps pc on itself
                    next_pc = ref_pc;
                    done = 1;
                end
            endcase
            ref_pc = next_pc;
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < depth; i++) begin
            rng = xorshift32(rng);
            image[i] = rng[15:0];
        end
    endtask

    // straight-line code with load first and halt last
    // stray bits above addr_w in the field are don't-care
    task automatic build_random(int len);
        cpu_pkg::opcode_e op;
        fill_random();
        for (int i = 0; i < len - 1; i++) begin
            rng = xorshift32(rng);
            op = (i == 0) ? cpu_pkg::op_load : cpu_pkg::opcode_e'(rng[3:0] % 4'd13);
            image[i] = {op, rng[27:24], 1'b1, rng[22:16]};
        end
        image[len - 1] = {cpu_pkg::op_halt, 12'h000};
    endtask

    // count down to zero while jz falls through until the last pass
    task automatic build_loop();
        fill_random();
        image[data_base] = 16'(rng[2:0]) + 16'd1;
        image[data_base + 1] = 16'd1;
        image[0] = {cpu_pkg::op_load, 12'(data_base)};
        image[1] = {cpu_pkg::op_jz, 12'd5};
        image[2] = {cpu_pkg::op_sub, 12'(data_base + 1)};
        image[3] = {cpu_pkg::op_store, 12'(data_base + 2)};
        image[4] = {cpu_pkg::op_jmp, 12'd1};
        image[5] = {cpu_pkg::op_halt, 12'h000};
    endtask

    task automatic load_image();
        for (int i = 0; i < depth; i++) begin
            ref_mem[i] = image[i];
            @(posedge clk);
            host_we <= 1'b1;
            host_addr <= addr_w'(i);
            host_wdata <= image[i];
        end
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    // host read data lags the address by one edge
    task automatic compare_memory();
        for (int i = 0; i <= depth; i++) begin
            @(posedge clk);
            if (i < depth) host_addr <= addr_w'(i);
            @(negedge clk);
            if (i > 0) check_value($sformatf("mem[%0d]", i - 1), host_rdata, ref_mem[i - 1]);
        end
    endtask

    // second start pulse lands mid run when extra_start is nonzero
    task automatic run_program(int extra_start);
        int cycles;
        @(posedge clk);
        start <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            start <= (cycles == extra_start);
            @(negedge clk);
        end while (!halted);
        interpret();
        check_value("halt_cycles", cycles, 3 * ref_steps + 1);
        check_value("acc", acc, ref_acc);
        check_value("pc", pc, ref_pc);
        compare_memory();
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        rng = 32'hc22b_db33;
        ref_acc = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // quiet machine after reset
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("halted", halted, 0);
        check_value("acc", acc, 0);
        check_value("pc", pc, 0);
        // each later program is loaded while halted
        for (int t = 0; t < n_random; t++) begin
            build_random(rand_len);
            load_image();
            run_program(0);
        end
        build_loop();
        load_image();
        run_program(0);
        // start during busy must change nothing
        build_random(rand_len);
        load_image();
        run_program(5);
        $display("All tests passed");
        $finish;
    end

endmodule

/* project.f */
src/cpu_pkg.sv
src/main_memory.sv
src/alu.sv
src/program_counter.sv
src/datapath.sv
src/control_fsm.sv
src/accumulator_cpu.sv
sim/cpu_asserts.sv
sim/cpu_tb.sv

/* Makefile */
TOP = cpu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
